/* sim.f */
+incdir+src
src/vnu_pkg.sv
src/vnu3_wr_fsm.sv
src/ib_map_fetch.sv
src/vnu_msg_ram.sv
src/vnu_wb_readback.sv
src/vnu_wr_top.sv
verif/vnu_wr_chk.sv
verif/vnu_wr_tb.sv

/* src/ib_map_fetch.sv */
`default_nettype none

`include "vnu_wr_config.svh"

// Interleaver map fetch, turns each write slot into two RAM locations
module ib_map_fetch (
   input  wire logic               write_clk,
   input  wire logic               rstn,
   input  wire logic               rom_port_fetch,   // Advance the map
   input  wire logic               v3ib_rom_rst,     // Restart at pair 0
   input  wire logic               ram_write_en,
   input  wire vnu_pkg::msg_pair_t ch_msg,           // Channel pair of this slot
   output vnu_pkg::ram_wr_t        ram_wr
);

   logic [`VNU_ROW_W-1:0] pair_cnt;     // Next entry pair to look up
   logic                  rom_primed;   // Address already presented once
   vnu_pkg::ib_entry_u    entry0_q;     // Map entry 2j, bank 0
   vnu_pkg::ib_entry_u    entry1_q;     // Map entry 2j+1, bank 1

   //////////////////////////////////////////////////////////////////////
   // Entry pair counter
   //////////////////////////////////////////////////////////////////////
   // The first fetch cycle only sets up the map address, so pair 0
   // is looked up twice and the counter starts moving one cycle later.
   // That lines pair j up with the edge just before slot j is written.
   always_ff @(posedge write_clk or negedge rstn) begin
      if (!rstn) begin
         pair_cnt   <= '0;
         rom_primed <= 1'b0;
      end else if (v3ib_rom_rst) begin
         pair_cnt   <= '0;                // Between iterations
         rom_primed <= 1'b0;
      end else if (rom_port_fetch) begin
         rom_primed <= 1'b1;
         if (rom_primed)
            pair_cnt <= pair_cnt + 1'b1;  // Wraps after the last pair
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Registered map lookup
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge write_clk) begin
      if (rom_port_fetch) begin
         entry0_q <= vnu_pkg::ib_perm({pair_cnt, 1'b0});   // Even entry
         entry1_q <= vnu_pkg::ib_perm({pair_cnt, 1'b1});   // Odd entry
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Write request
   //////////////////////////////////////////////////////////////////////
   // Even entries always decode to bank 0 and odd ones to bank 1,
   // only the row part of each location is needed here
   always_comb begin
      ram_wr.en   = ram_write_en;
      ram_wr.row0 = entry0_q.loc.row;
      ram_wr.row1 = entry1_q.loc.row;
      ram_wr.data = ch_msg;               // Same edge as the write
   end

endmodule

`default_nettype wire

/* src/vnu3_wr_fsm.sv */
`default_nettype none

// Write control for one variable-node iteration update
module vnu3_wr_fsm #(
   parameter int LOAD_CYCLE = 64   // 128 entries / 2 banks
) (
   input  wire logic       write_clk,
   input  wire logic       rstn,
   input  wire logic       iter_rqst,
   input  wire logic       iter_termination,
   output logic            rom_port_fetch,   // Interleaver map fetch enable
   output logic            ram_write_en,
   output logic            ram_mux_en,       // Memory owned by the update
   output logic            iter_update,
   output logic            v3ib_rom_rst,     // Clears the map counter
   output logic [1:0]      busy,             // 00 idle, 01 updating, 10 done
   output logic [2:0]      state
);

   localparam int CNT_W = $clog2(LOAD_CYCLE);

   localparam logic [2:0] IDLE       = 3'b000;
   localparam logic [2:0] ROM_FETCH0 = 3'b001;   // Map address setup, first slot only
   localparam logic [2:0] RAM_LOAD0  = 3'b010;
   localparam logic [2:0] RAM_LOAD1  = 3'b011;   // One slot written per cycle
   localparam logic [2:0] FINISH     = 3'b100;

   logic [CNT_W-1:0] slot_cnt;     // Current write slot
   logic             finish_cond;  // Stop early
   logic             last_slot;
   logic [6:0]       ctrl;         // Decoded output word

   assign finish_cond = iter_termination | ~iter_rqst;
   assign last_slot   = (slot_cnt == CNT_W'(LOAD_CYCLE - 1));

   //////////////////////////////////////////////////////////////////////
   // Slot counter, runs only while writing
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge write_clk or negedge rstn) begin
      if (!rstn) begin
         slot_cnt <= '0;
      end else if (!ram_write_en) begin
         slot_cnt <= '0;                   // Idle between loads
      end else begin
         slot_cnt <= slot_cnt + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // State register
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge write_clk or negedge rstn) begin
      if (!rstn) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (iter_rqst && !iter_termination)
                  state <= ROM_FETCH0;     // New iteration
            end
            ROM_FETCH0: state <= RAM_LOAD0;
            RAM_LOAD0: begin
               if (finish_cond) state <= FINISH;
               else             state <= RAM_LOAD1;
            end
            RAM_LOAD1: begin
               // Slot of this edge is still written on early exit
               if (finish_cond || last_slot) state <= FINISH;
            end
            FINISH: begin
               // Hold until the requester lets go
               if (!iter_rqst) state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Output decode
   // {rom_port_fetch, ram_mux_en, ram_write_en, iter_update, v3ib_rom_rst, busy}
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      case (state)
         IDLE:       ctrl = 7'b0000100;
         ROM_FETCH0: ctrl = 7'b1001001;
         RAM_LOAD0:  ctrl = 7'b1101001;
         RAM_LOAD1:  ctrl = 7'b1111001;   // Write slot
         default:    ctrl = 7'b0000110;   // FINISH
      endcase
   end

   assign {rom_port_fetch, ram_mux_en, ram_write_en, iter_update, v3ib_rom_rst, busy} = ctrl;

endmodule

`default_nettype wire

/* src/vnu_msg_ram.sv */
`default_nettype none

`include "vnu_wr_config.svh"

// Two-bank variable-node message memory
module vnu_msg_ram (
   input  wire logic                  write_clk,
   input  wire vnu_pkg::ram_wr_t      ram_wr,    // Dual write, one row per bank
   input  wire logic [`VNU_ROW_W-1:0] rd_row,
   input  wire logic                  rd_bank,   // 0 even index, 1 odd index
   output vnu_pkg::msg_t              rd_data    // One cycle after rd_row
);

   localparam int DEPTH = `VNU_LOAD_CYCLE;   // Rows per bank

   vnu_pkg::msg_t bank0_mem [DEPTH];   // Even flat indices
   vnu_pkg::msg_t bank1_mem [DEPTH];   // Odd flat indices

   //////////////////////////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////////////////////////
   // Both banks take their message in the same cycle
   always_ff @(posedge write_clk) begin
      if (ram_wr.en) begin
         bank0_mem[ram_wr.row0] <= ram_wr.data.msg0;
         bank1_mem[ram_wr.row1] <= ram_wr.data.msg1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read port
   //////////////////////////////////////////////////////////////////////
   // Registered, old data on a same-cycle write
   always_ff @(posedge write_clk) begin
      if (rd_bank)
         rd_data <= bank1_mem[rd_row];
      else
         rd_data <= bank0_mem[rd_row];
   end

endmodule

`default_nettype wire

/* src/vnu_pkg.sv */
`default_nettype none

`include "vnu_wr_config.svh"

package vnu_pkg;

   typedef logic signed [`VNU_MSG_W-1:0] msg_t;   // One LLR message

   // Both messages of one write slot, msg0 to bank 0, msg1 to bank 1
   typedef struct packed {
      msg_t msg0;
      msg_t msg1;
   } msg_pair_t;

   // Row and bank view of a flat index, bank is the low bit
   typedef struct packed {
      logic [`VNU_ROW_W-1:0] row;
      logic                  bank;
   } ib_loc_t;

   // One index word, read either flat or as a bank location
   typedef union packed {
      logic [`VNU_IDX_W-1:0] flat;
      ib_loc_t               loc;
   } ib_entry_u;

   // Dual write request into the message RAM
   typedef struct packed {
      logic                  en;
      logic [`VNU_ROW_W-1:0] row0;   // Bank 0 row
      logic [`VNU_ROW_W-1:0] row1;   // Bank 1 row
      msg_pair_t             data;
   } ram_wr_t;

   // Wishbone classic, master to slave
   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [`VNU_IDX_W-1:0] adr;
      msg_t                  dat;
   } wb_m2s_t;

   // Wishbone classic, slave to master
   typedef struct packed {
      logic ack;
      msg_t dat;
   } wb_s2m_t;

   // Fixed interleaver map, entry number to permuted location
   function automatic ib_entry_u ib_perm(input logic [`VNU_IDX_W-1:0] k);
      logic [2*`VNU_IDX_W-1:0] prod;   // Wide enough for 127*37+10
      ib_entry_u               e;
      prod = (2*`VNU_IDX_W)'(k) * (2*`VNU_IDX_W)'(`VNU_IB_STRIDE)
           + (2*`VNU_IDX_W)'(`VNU_IB_OFFSET);
      e.flat = prod[`VNU_IDX_W-1:0];   // mod 128
      return e;
   endfunction

endpackage

`default_nettype wire

/* src/vnu_wb_readback.sv */
`default_nettype none

`include "vnu_wr_config.svh"

// Wishbone classic slave for message read-back
module vnu_wb_readback (
   input  wire logic                  write_clk,
   input  wire logic                  rstn,
   input  wire vnu_pkg::wb_m2s_t      wb_in,
   input  wire logic                  ram_mux_en,   // Update owns the RAM
   input  wire vnu_pkg::msg_t         rd_data,
   output vnu_pkg::wb_s2m_t           wb_out,
   output logic [`VNU_ROW_W-1:0]      rd_row,
   output logic                       rd_bank
);

   localparam logic [1:0] RB_IDLE = 2'd0;   // Wait for a request
   localparam logic [1:0] RB_READ = 2'd1;   // RAM read in flight
   localparam logic [1:0] RB_ACK  = 2'd2;   // Data on the bus

   logic [1:0]         rb_state;
   vnu_pkg::ib_entry_u adr_q;    // Latched flat index
   logic               we_q;     // Write cycle, acked only

   //////////////////////////////////////////////////////////////////////
   // Request sequencer
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge write_clk or negedge rstn) begin
      if (!rstn) begin
         rb_state <= RB_IDLE;
      end else begin
         case (rb_state)
            RB_IDLE: begin
               if (wb_in.cyc && wb_in.stb && !ram_mux_en)
                  rb_state <= RB_READ;
            end
            RB_READ: begin
               // Update took the RAM meanwhile, retry later
               if (ram_mux_en) rb_state <= RB_IDLE;
               else            rb_state <= RB_ACK;
            end
            default: rb_state <= RB_IDLE;   // Single-cycle ack
         endcase
      end
   end

   // Address and cycle type, master holds them until ack
   always_ff @(posedge write_clk) begin
      if (rb_state == RB_IDLE) begin
         adr_q.flat <= wb_in.adr;
         we_q       <= wb_in.we;
      end
   end

   // Flat index to bank location
   assign rd_row  = adr_q.loc.row;
   assign rd_bank = adr_q.loc.bank;

   always_comb begin
      wb_out.ack = (rb_state == RB_ACK);
      wb_out.dat = we_q ? '0 : rd_data;   // Nothing to return on writes
   end

endmodule

`default_nettype wire

/* src/vnu_wr_config.svh */
`ifndef VNU_WR_CONFIG_SVH
`define VNU_WR_CONFIG_SVH

// Iteration update geometry
`define VNU_LOAD_CYCLE 64   // Write slots per iteration, 128 entries over 2 banks

// Message and address widths
`define VNU_MSG_W      8    // Signed LLR message
`define VNU_IDX_W      7    // Flat message index, 0..127
`define VNU_ROW_W      6    // Row inside one bank

// Interleaver rule: perm(k) = (k * STRIDE + OFFSET) mod 128
// Odd stride keeps parity of k, even offset keeps it too,
// so even entries land in bank 0 and odd entries in bank 1
`define VNU_IB_STRIDE  37
`define VNU_IB_OFFSET  10

`endif

/* src/vnu_wr_top.sv */
`default_nettype none

`include "vnu_wr_config.svh"

// Variable-node message update with Wishbone read-back
module vnu_wr_top (
   input  wire logic               write_clk,
   input  wire logic               rstn,
   input  wire logic               iter_rqst,
   input  wire logic               iter_termination,
   input  wire vnu_pkg::msg_pair_t ch_msg,
   input  wire vnu_pkg::wb_m2s_t   wb_in,
   output vnu_pkg::wb_s2m_t        wb_out,
   output logic [1:0]              busy
);

   logic                  rom_port_fetch;
   logic                  v3ib_rom_rst;
   logic                  ram_write_en;
   logic                  ram_mux_en;     // Read-back hold-off
   vnu_pkg::ram_wr_t      ram_wr;         // Producer to RAM
   logic [`VNU_ROW_W-1:0] rd_row;
   logic                  rd_bank;
   vnu_pkg::msg_t         rd_data;

   //////////////////////////////////////////////////////////////////////
   // Control
   //////////////////////////////////////////////////////////////////////
   vnu3_wr_fsm #(
      .LOAD_CYCLE       (`VNU_LOAD_CYCLE)
   ) u_fsm (
      .write_clk        (write_clk),
      .rstn             (rstn),
      .iter_rqst        (iter_rqst),
      .iter_termination (iter_termination),
      .rom_port_fetch   (rom_port_fetch),
      .ram_write_en     (ram_write_en),
      .ram_mux_en       (ram_mux_en),
      .iter_update      (),               // Not used at this level
      .v3ib_rom_rst     (v3ib_rom_rst),
      .busy             (busy),
      .state            ()
   );

   //////////////////////////////////////////////////////////////////////
   // Data path
   //////////////////////////////////////////////////////////////////////
   ib_map_fetch u_fetch (
      .write_clk      (write_clk),
      .rstn           (rstn),
      .rom_port_fetch (rom_port_fetch),
      .v3ib_rom_rst   (v3ib_rom_rst),
      .ram_write_en   (ram_write_en),
      .ch_msg         (ch_msg),
      .ram_wr         (ram_wr)
   );

   vnu_msg_ram u_ram (
      .write_clk (write_clk),
      .ram_wr    (ram_wr),
      .rd_row    (rd_row),
      .rd_bank   (rd_bank),
      .rd_data   (rd_data)
   );

   vnu_wb_readback u_wb (
      .write_clk  (write_clk),
      .rstn       (rstn),
      .wb_in      (wb_in),
      .ram_mux_en (ram_mux_en),
      .rd_data    (rd_data),
      .wb_out     (wb_out),
      .rd_row     (rd_row),
      .rd_bank    (rd_bank)
   );

endmodule

`default_nettype wire

/* verif/vnu_wr_chk.sv */
`default_nettype none

// FSM property checks, bound into every vnu3_wr_fsm
module vnu_wr_chk #(
   parameter int LOAD_CYCLE = 64
) (
   input wire logic                          write_clk,
   input wire logic                          rstn,
   input wire logic                          iter_rqst,
   input wire logic [2:0]                    state,
   input wire logic [1:0]                    busy,
   input wire logic                          rom_port_fetch,
   input wire logic                          ram_write_en,
   input wire logic [$clog2(LOAD_CYCLE)-1:0] slot_cnt
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [2:0] FINISH = 3'b100;   // FSM encoding of FINISH

   // Only 00, 01 and 10 are legal busy codes
   busy_code_a: assert property (@(posedge write_clk) disable iff (!rstn)
      busy != 2'b11)
      else $error("busy shows the unused code 11");

   // A RAM write needs its map entry in flight
   write_fetch_a: assert property (@(posedge write_clk) disable iff (!rstn)
      ram_write_en |-> rom_port_fetch)
      else $error("RAM write without map fetch");

   // Last slot ends the load, the counter never wraps into a new slot
   slot_range_a: assert property (@(posedge write_clk) disable iff (!rstn)
      (ram_write_en && int'(slot_cnt) == LOAD_CYCLE - 1) |=> !ram_write_en)
      else $error("slot counter past the last slot");

   // FINISH waits for the request to drop
   finish_hold_a: assert property (@(posedge write_clk) disable iff (!rstn)
      (state == FINISH && iter_rqst) |=> state == FINISH)
      else $error("FINISH left while the request was still high");

endmodule

`default_nettype wire

/* verif/vnu_wr_patterns.txt */
# name  term_slot  drop_slot  readback_count   (decimal, one case per line)
# slot 64 means no termination or no request drop; the first case must be a full load
full_load_first      64  64  128
term_at_slot_0        0  64  128
term_at_slot_17      17  64   40
full_load_again      64  64  128
drop_at_slot_0       64   0  128
drop_at_slot_31      64  31   48
term_at_slot_63      63  64   32
drop_at_slot_63      64  63  128
term_before_drop     12  40  128
drop_before_term     50  22   64
same_slot_both        9   9  128
term_at_slot_5        5  64   16
drop_at_slot_44      64  44   24
full_load_hold       64  64   64
term_at_slot_58      58  64  128
drop_at_slot_2       64   2   20
full_load_last       64  64  128

/* verif/vnu_wr_tb.sv */
`default_nettype none

`include "vnu_wr_config.svh"

module vnu_wr_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_IDX   = 2 * `VNU_LOAD_CYCLE;   // Flat message indices
   localparam int TIMEOUT = 200;                   // Cycles allowed per wait

   logic               write_clk;
   logic               rstn;
   logic               iter_rqst;
   logic               iter_termination;
   vnu_pkg::msg_pair_t ch_msg;
   vnu_pkg::wb_m2s_t   wb_in;
   vnu_pkg::wb_s2m_t   wb_out;
   logic [1:0]         busy;

   vnu_pkg::msg_t model [N_IDX];   // Expected RAM contents by flat index
   int            seed = 40070;
   string         test_name;

   vnu_wr_top vnu_wr_top_inst (.*);

   bind vnu3_wr_fsm vnu_wr_chk #(.LOAD_CYCLE(LOAD_CYCLE)) fsm_chk (.*);

   initial begin
      write_clk = 1'b0;
      forever #10 write_clk = ~write_clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////
   function automatic int perm_index(input int k);
      return (k * `VNU_IB_STRIDE + `VNU_IB_OFFSET) % N_IDX;   // Map rule
   endfunction

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("tests failed");
      $fatal(1, "stopping on first error");
   endtask

   task automatic mismatch(input string what, input logic signed [31:0] expected,
                           input logic signed [31:0] actual);
      stop_run($sformatf("MISMATCH %s: %s expected %0d actual %0d",
                         test_name, what, expected, actual));
   endtask

   // Falling-edge poll of busy, optionally no ack while updating
   task automatic wait_busy(input logic [1:0] code, input bit no_ack);
      int n;
      n = 0;
      while (busy !== code) begin
         @(negedge write_clk);
         if (no_ack && busy == 2'b01)
            assert (wb_out.ack == 1'b0)
               else stop_run("Wishbone ack arrived while the update owned the RAM");
         n++;
         if (n > TIMEOUT)
            stop_run($sformatf("timeout in %s waiting for busy %b", test_name, code));
      end
   endtask

   task automatic wb_start(input bit we, input int idx, input vnu_pkg::msg_t wdat);
      vnu_pkg::wb_m2s_t req;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = we;
      req.adr = idx[`VNU_IDX_W-1:0];
      req.dat = wdat;
      @(posedge write_clk);
      wb_in <= req;                    // Held until ack
   endtask

   task automatic wb_finish(output vnu_pkg::msg_t rdat);
      int n;
      n = 0;
      do begin
         @(negedge write_clk);
         n++;
         if (n > TIMEOUT) stop_run($sformatf("timeout in %s waiting for ack", test_name));
      end while (wb_out.ack !== 1'b1);
      rdat = wb_out.dat;
      @(posedge write_clk);
      wb_in <= '0;                     // End of cycle
      @(negedge write_clk);
   endtask

   task automatic check_read(input int idx);
      vnu_pkg::msg_t rdat;
      wb_start(1'b0, idx, '0);
      wb_finish(rdat);
      assert (rdat === model[idx])
         else mismatch($sformatf("read index %0d", idx), model[idx], rdat);
   endtask

   //////////////////////////////////////////////////////////////////////
   // One iteration update with a held read-back
   //////////////////////////////////////////////////////////////////////
   task automatic run_iteration(input int term_slot, input int drop_slot, input int bp_idx);
      vnu_pkg::msg_pair_t msg;
      vnu_pkg::msg_t      rdat;
      int                 last;
      last = `VNU_LOAD_CYCLE - 1;
      if (term_slot < last) last = term_slot;
      if (drop_slot < last) last = drop_slot;
      @(posedge write_clk);
      iter_rqst <= 1'b1;
      wait_busy(2'b01, 1'b0);          // ROM_FETCH0 entered
      wb_start(1'b0, bp_idx, '0);      // Must wait out the update
      for (int j = 0; j <= last; j++) begin
         @(posedge write_clk);         // Sampled one edge later, slot j
         msg.msg0 = 8'($random(seed));
         msg.msg1 = 8'($random(seed));
         ch_msg <= msg;
         if (j == term_slot) iter_termination <= 1'b1;
         if (j == drop_slot) iter_rqst <= 1'b0;
         model[perm_index(2 * j)]     = msg.msg0;   // Bank 0 entry
         model[perm_index(2 * j + 1)] = msg.msg1;   // Bank 1 entry
         @(negedge write_clk);
         assert (!(busy == 2'b01 && wb_out.ack))
            else stop_run("Wishbone ack arrived while the update owned the RAM");
      end
      wait_busy(2'b10, 1'b1);
      wb_finish(rdat);
      assert (rdat === model[bp_idx]) else mismatch("held read", model[bp_idx], rdat);
      if (drop_slot > last) begin
         // Request still high, FINISH holds
         repeat (4) begin
            @(negedge write_clk);
            assert (busy == 2'b10) else mismatch("busy in hold", 2, busy);
         end
         @(posedge write_clk);
         iter_rqst <= 1'b0;
      end
      @(posedge write_clk);
      iter_termination <= 1'b0;
      wait_busy(2'b00, 1'b0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      int            fd;
      int            term_slot;
      int            drop_slot;
      int            rb_count;
      int            base;
      int            n_tests;
      string         line;
      vnu_pkg::msg_t rdat;
      rstn             = 1'b0;
      iter_rqst        = 1'b0;
      iter_termination = 1'b0;
      ch_msg           = '0;
      wb_in            = '0;
      n_tests          = 0;
      repeat (3) @(posedge write_clk);
      rstn <= 1'b1;
      @(negedge write_clk);
      test_name = "reset_state";
      assert (busy == 2'b00) else mismatch("busy", 0, busy);
      assert (wb_out.ack == 1'b0) else mismatch("ack", 0, wb_out.ack);

      fd = $fopen("verif/vnu_wr_patterns.txt", "r");
      if (fd == 0) stop_run("cannot open verif/vnu_wr_patterns.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line[0] == "#") continue;   // Column notes
         if ($sscanf(line, "%s %d %d %d", test_name, term_slot, drop_slot, rb_count) != 4)
            continue;
         n_tests++;
         run_iteration(term_slot, drop_slot, $random(seed) & (N_IDX - 1));
         // Write cycle is acked but leaves the RAM alone
         base = $random(seed) & (N_IDX - 1);
         wb_start(1'b1, base, 8'($random(seed)));
         wb_finish(rdat);
         check_read(base);
         base = $random(seed) & (N_IDX - 1);
         for (int i = 0; i < rb_count; i++)
            check_read((base + i) % N_IDX);
      end
      $fclose(fd);

      if (n_tests == 0) begin
         stop_run("no test case found in verif/vnu_wr_patterns.txt");
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire
